/* common/pix_bus_if.sv */
/*
 * pixel bus from the frame-start latch
 * carries sync levels, all taps packed, and the
 * settings latched for the current frame
 */
`timescale 1ns/10ps
`default_nettype none

interface pix_bus_if #(
	parameter int DATA_WIDTH  = 8,
	parameter int CHANNEL_NUM = 4
);
	import pix_corr_pkg::*;

	logic                                fval;        // frame valid level
	logic                                lval;        // line valid level
	logic [DATA_WIDTH*CHANNEL_NUM-1:0]   data;        // tap 0 in the low bits
	corr_mode_e                          mode;
	logic [DATA_WIDTH-1:0]               black_level;
	logic [GAIN_WIDTH-1:0]               gain;

	// latch side
	modport src (output fval, lval, data, mode, black_level, gain);

	// per-tap correction, pixels and settings only
	modport tap_snk (input data, mode, black_level, gain);

	// sync aligner
	modport sync_snk (input fval, lval);

endinterface : pix_bus_if

`default_nettype wire

/* common/pix_corr_pkg.sv */
/*
 * pixel correction definitions
 * mode opcodes and the fixed-point gain format
 */
`default_nettype none

package pix_corr_pkg;

	// --------------------------------------------------
	// correction opcode
	// --------------------------------------------------
	typedef enum logic [1:0] {
		CM_BYPASS      = 2'd0, // pixel unchanged
		CM_OFFSET      = 2'd1, // black level only
		CM_OFFSET_GAIN = 2'd2  // black level then gain
	} corr_mode_e;

	// --------------------------------------------------
	// gain format, unsigned 4.4 fixed point
	// --------------------------------------------------
	localparam int GAIN_WIDTH = 8;
	localparam int GAIN_FRAC  = 4; // 16 is unity

	// half an lsb of the product, rounds half up
	localparam int GAIN_ROUND = 1 << (GAIN_FRAC - 1);

endpackage : pix_corr_pkg

`default_nettype wire

/* common/pix_timing_pkg.sv */
/*
 * pixel path timing definitions
 * pipeline depth, frame lead of the sync aligner
 * and the state of the frame-start latch
 */
`default_nettype none

package pix_timing_pkg;

	// --------------------------------------------------
	// alignment constants
	// --------------------------------------------------
	// per-tap correction depth, also the lval delay
	localparam int TAP_LATENCY = 3;

	// fval rise delay, frame lead ahead of first line
	localparam int FVAL_LEAD = 6;

	// --------------------------------------------------
	// frame-start latch state
	// --------------------------------------------------
	typedef enum logic {
		FS_IDLE   = 1'b0, // waiting for fval rise
		FS_ACTIVE = 1'b1  // settings held for the frame
	} frame_state_e;

endpackage : pix_timing_pkg

`default_nettype wire

/* list.f */
common/pix_timing_pkg.sv
common/pix_corr_pkg.sv
common/pix_bus_if.sv
source/frame_param_latch.sv
pix_corr/pix_gain_offset.sv
source/fval_lval_phase.sv
source/pix_corr_top.sv
verif/pix_corr_checker.sv
verif/pix_corr_tb.sv

/* pix_corr/pix_gain_offset.sv */
/*
 * per-tap correction pipeline, three stages
 * black level subtract with clamp, fixed-point gain,
 * round half up and saturate to full scale
 */
`timescale 1ns/10ps
`default_nettype none

module pix_gain_offset #(
	parameter int DATA_WIDTH  = 8,
	parameter int CHANNEL_NUM = 4,
	parameter int TAP_INDEX   = 0
) (
	input  wire logic              clk,
	input  wire logic              i_arst_n,
	pix_bus_if.tap_snk             i_bus,
	output      logic [DATA_WIDTH-1:0] o_pix
);
	import pix_corr_pkg::*;

	localparam int PROD_WIDTH = DATA_WIDTH + GAIN_WIDTH;

	logic [DATA_WIDTH*CHANNEL_NUM-1:0] bus_data;
	logic [DATA_WIDTH-1:0]             pix_in;   // this tap's slice
	corr_mode_e                        s1_mode, s2_mode;
	logic [DATA_WIDTH-1:0]             s1_val;
	logic [GAIN_WIDTH-1:0]             s1_gain;
	logic [PROD_WIDTH-1:0]             s2_prod;
	logic [PROD_WIDTH-1:0]             rnd_sum;
	logic [PROD_WIDTH-1:0]             rnd_shift;

	assign bus_data = i_bus.data;
	assign pix_in   = bus_data[TAP_INDEX*DATA_WIDTH +: DATA_WIDTH];

	// product fits with the round half added, no carry out
	assign rnd_sum   = s2_prod + PROD_WIDTH'(GAIN_ROUND);
	assign rnd_shift = rnd_sum >> GAIN_FRAC;

	// mode travels with its pixel
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			s1_mode <= CM_BYPASS;
			s2_mode <= CM_BYPASS;
		end else begin
			s1_mode <= i_bus.mode;
			s2_mode <= s1_mode;
		end
	end

	// --------------------------------------------------
	// datapath stages
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		// stage 1, black level with clamp at zero
		if (i_bus.mode == CM_BYPASS)
			s1_val <= pix_in;
		else
			s1_val <= (pix_in > i_bus.black_level) ? pix_in - i_bus.black_level : '0;
		s1_gain <= i_bus.gain;

		// stage 2, full-width product
		if (s1_mode == CM_OFFSET_GAIN)
			s2_prod <= PROD_WIDTH'(s1_val) * PROD_WIDTH'(s1_gain);
		else
			s2_prod <= PROD_WIDTH'(s1_val); // passthrough, zero extended

		// stage 3, drop fraction and saturate
		if (s2_mode == CM_OFFSET_GAIN)
			o_pix <= (|rnd_shift[PROD_WIDTH-1:DATA_WIDTH]) ? '1
				: rnd_shift[DATA_WIDTH-1:0];
		else
			o_pix <= s2_prod[DATA_WIDTH-1:0];
	end

endmodule : pix_gain_offset

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module pix_corr_tb \
	-f list.f \
	-o pix_corr_sim

./obj_dir/pix_corr_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Regression passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

/* source/frame_param_latch.sv */
/*
 * frame-start latch
 * registers sync and pixel inputs once and captures
 * mode, black level and gain when a frame begins,
 * so settings stay fixed for the whole frame
 */
`timescale 1ns/10ps
`default_nettype none

module frame_param_latch #(
	parameter int DATA_WIDTH  = 8,
	parameter int CHANNEL_NUM = 4
) (
	input  wire logic                                   clk,
	input  wire logic                                   i_arst_n,
	input  wire logic                                   i_fval,
	input  wire logic                                   i_lval,
	input  wire logic [DATA_WIDTH*CHANNEL_NUM-1:0]      i_data,
	input  wire pix_corr_pkg::corr_mode_e               i_mode,
	input  wire logic [DATA_WIDTH-1:0]                  i_black_level,
	input  wire logic [pix_corr_pkg::GAIN_WIDTH-1:0]    i_gain,
	pix_bus_if.src                                      o_bus
);
	import pix_timing_pkg::*;
	import pix_corr_pkg::*;

	frame_state_e state;
	logic         frame_start; // first fval high seen while idle

	assign frame_start = (state == FS_IDLE) && i_fval;

	// --------------------------------------------------
	// frame state and settings capture
	// --------------------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state             <= FS_IDLE;
			o_bus.mode        <= CM_BYPASS;
			o_bus.black_level <= '0;
			o_bus.gain        <= '0;
		end else begin
			case (state)
				FS_IDLE: begin
					if (frame_start) begin
						state             <= FS_ACTIVE;
						o_bus.mode        <= i_mode;        // same edge as first fval
						o_bus.black_level <= i_black_level;
						o_bus.gain        <= i_gain;
					end
				end
				FS_ACTIVE: begin
					if (!i_fval)
						state <= FS_IDLE; // rearm for next frame
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

	// sync levels, one cycle of latency
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_bus.fval <= 1'b0;
			o_bus.lval <= 1'b0;
		end else begin
			o_bus.fval <= i_fval;
			o_bus.lval <= i_lval;
		end
	end

	// pixel payload, matched to the sync delay
	always_ff @(posedge clk) begin
		o_bus.data <= i_data;
	end

endmodule : frame_param_latch

`default_nettype wire

/* source/fval_lval_phase.sv */
/*
 * sync aligner after the tap pipelines
 * delays lval by the pipeline depth, delays the fval
 * rise for a frame lead, lets fval fall at once,
 * and blanks pixels outside the aligned line
 */
`timescale 1ns/10ps
`default_nettype none

module fval_lval_phase #(
	parameter int DATA_WIDTH  = 8,
	parameter int CHANNEL_NUM = 4
) (
	input  wire logic                              clk,
	input  wire logic                              i_arst_n,
	pix_bus_if.sync_snk                            i_bus,
	input  wire logic [DATA_WIDTH*CHANNEL_NUM-1:0] i_tap_data,
	output      logic                              o_fval,
	output      logic                              o_lval,
	output      logic [DATA_WIDTH*CHANNEL_NUM-1:0] o_data
);
	import pix_timing_pkg::*;

	logic [FVAL_LEAD-1:0]   fval_shift; // rise delay line
	logic [TAP_LATENCY-1:0] lval_shift; // matches tap depth

	// --------------------------------------------------
	// sync delay lines
	// --------------------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			fval_shift <= '0;
			lval_shift <= '0;
		end else begin
			fval_shift <= {fval_shift[FVAL_LEAD-2:0], i_bus.fval};
			lval_shift <= {lval_shift[TAP_LATENCY-2:0], i_bus.lval};
		end
	end

	// late rise, immediate fall
	assign o_fval = fval_shift[FVAL_LEAD-1] & i_bus.fval;
	assign o_lval = lval_shift[TAP_LATENCY-1];

	// zero between lines and frames
	assign o_data = o_lval ? i_tap_data : '0;

endmodule : fval_lval_phase

`default_nettype wire

/* source/pix_corr_top.sv */
/*
 * pixel correction path, top level
 * frame-start latch, one correction pipeline per tap
 * and the sync aligner
 */
`timescale 1ns/10ps
`default_nettype none

module pix_corr_top #(
	parameter int DATA_WIDTH  = 8,
	parameter int CHANNEL_NUM = 4
) (
	input  wire logic                              clk,
	input  wire logic                              i_arst_n,
	input  wire logic                              i_fval,
	input  wire logic                              i_lval,
	input  wire logic [DATA_WIDTH*CHANNEL_NUM-1:0] i_data,
	input  wire logic [1:0]                        i_mode,        // corr_mode_e code
	input  wire logic [DATA_WIDTH-1:0]             i_black_level,
	input  wire logic [pix_corr_pkg::GAIN_WIDTH-1:0] i_gain,
	output      logic                              o_fval,
	output      logic                              o_lval,
	output      logic [DATA_WIDTH*CHANNEL_NUM-1:0] o_data
);
	import pix_corr_pkg::*;

	logic [DATA_WIDTH*CHANNEL_NUM-1:0] tap_data; // corrected taps, packed

	pix_bus_if #(.DATA_WIDTH(DATA_WIDTH), .CHANNEL_NUM(CHANNEL_NUM)) pix_bus ();

	frame_param_latch #(.DATA_WIDTH(DATA_WIDTH), .CHANNEL_NUM(CHANNEL_NUM)) u_latch (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_fval        (i_fval),
		.i_lval        (i_lval),
		.i_data        (i_data),
		.i_mode        (corr_mode_e'(i_mode)),
		.i_black_level (i_black_level),
		.i_gain        (i_gain),
		.o_bus         (pix_bus)
	);

	// --------------------------------------------------
	// one pipeline per tap
	// --------------------------------------------------
	for (genvar g = 0; g < CHANNEL_NUM; g++) begin : g_tap
		pix_gain_offset #(
			.DATA_WIDTH  (DATA_WIDTH),
			.CHANNEL_NUM (CHANNEL_NUM),
			.TAP_INDEX   (g)
		) u_tap (
			.clk      (clk),
			.i_arst_n (i_arst_n),
			.i_bus    (pix_bus),
			.o_pix    (tap_data[g*DATA_WIDTH +: DATA_WIDTH])
		);
	end

	fval_lval_phase #(.DATA_WIDTH(DATA_WIDTH), .CHANNEL_NUM(CHANNEL_NUM)) u_phase (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_bus      (pix_bus),
		.i_tap_data (tap_data),
		.o_fval     (o_fval),
		.o_lval     (o_lval),
		.o_data     (o_data)
	);

endmodule : pix_corr_top

`default_nettype wire

/* verif/pix_corr_checker.sv */
/*
 * sync checks on the pixel correction top level
 * line inside frame, blanking, lval and fval phase
 */
`timescale 1ns/10ps
`default_nettype none

module pix_corr_checker #(
	parameter int DATA_WIDTH  = 8,
	parameter int CHANNEL_NUM = 4
) (
	input wire logic                              clk,
	input wire logic                              i_arst_n,
	input wire logic                              i_fval,
	input wire logic                              i_lval,
	input wire logic                              o_fval,
	input wire logic                              o_lval,
	input wire logic [DATA_WIDTH*CHANNEL_NUM-1:0] o_data
);
	// --------------------------------------------------
	// output sync shape
	// --------------------------------------------------
	a_lval_in_fval: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_lval |-> o_fval)
		else $error("o_lval high outside o_fval");

	a_blank_data: assert property (@(posedge clk) disable iff (!i_arst_n)
		!o_lval |-> (o_data == '0))
		else $error("o_data not blank between lines");

	// latch register plus three tap stages
	a_lval_phase: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(i_lval) |-> ##4 $rose(o_lval))
		else $error("o_lval did not rise 4 cycles after i_lval");

	a_fval_fall: assert property (@(posedge clk) disable iff (!i_arst_n)
		$fell(i_fval) |=> !o_fval)
		else $error("o_fval still high 1 cycle after i_fval fell");

endmodule : pix_corr_checker

bind pix_corr_top pix_corr_checker #(
	.DATA_WIDTH  (DATA_WIDTH),
	.CHANNEL_NUM (CHANNEL_NUM)
) u_checker (
	.clk      (clk),
	.i_arst_n (i_arst_n),
	.i_fval   (i_fval),
	.i_lval   (i_lval),
	.o_fval   (o_fval),
	.o_lval   (o_lval),
	.o_data   (o_data)
);

`default_nettype wire

/* verif/pix_corr_tb.sv */
/*
 * testbench for the pixel correction path
 * frames from the test table, random pixels,
 * reference pixel model and sync shape checks
 */
`timescale 1ns/10ps
`default_nettype none

module pix_corr_tb;
	import pix_corr_pkg::*;

	localparam int DATA_WIDTH  = 8;
	localparam int CHANNEL_NUM = 4;
	localparam int W           = DATA_WIDTH * CHANNEL_NUM;
	localparam int PIX_MAX     = (1 << DATA_WIDTH) - 1;

	logic                  clk = 1'b0;
	logic                  i_arst_n, i_fval, i_lval;
	logic [W-1:0]          i_data;
	logic [1:0]            i_mode;
	logic [DATA_WIDTH-1:0] i_black_level;
	logic [GAIN_WIDTH-1:0] i_gain;
	logic                  o_fval, o_lval;
	logic [W-1:0]          o_data;

	string t_name[$];                                   // test table
	int    t_mode[$], t_blk[$], t_gain[$], t_lines[$], t_pix[$];

	logic [31:0]           lfsr = 32'h4b3c_e5e0;
	logic [W-1:0]          exp_q[$];                    // expected words in order
	logic [6:0]            fval_hist = '0;              // driven fval, newest in bit 0
	logic [3:0]            lval_hist = '0;
	logic                  prev_lval = 1'b0;
	logic                  nxt_rst_n;
	logic [1:0]            nxt_mode;
	logic [DATA_WIDTH-1:0] nxt_blk;
	logic [GAIN_WIDTH-1:0] nxt_gain;
	int    cycle_cnt = 0, cycle_limit = 0;
	int    err_cnt = 0, test_err = 0, pulse_cnt = 0, pass_cnt = 0, fail_cnt = 0;
	string cur_name = "power_on_reset";

	always #4 clk = ~clk;

	pix_corr_top #(.DATA_WIDTH(DATA_WIDTH), .CHANNEL_NUM(CHANNEL_NUM)) dut (
		.clk (clk), .i_arst_n (i_arst_n), .i_fval (i_fval), .i_lval (i_lval),
		.i_data (i_data), .i_mode (i_mode), .i_black_level (i_black_level),
		.i_gain (i_gain), .o_fval (o_fval), .o_lval (o_lval), .o_data (o_data)
	);

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("timeout, the run did not end within %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// stimulus and reference model
	// --------------------------------------------------
	// fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] corr_pix(input int mode, input int blk,
			input int gain, input int pix);
		int     d;
		longint p;
		d = (pix > blk) ? pix - blk : 0; // clamp at zero
		if (mode == int'(CM_BYPASS))
			return DATA_WIDTH'(pix);
		if (mode == int'(CM_OFFSET))
			return DATA_WIDTH'(d);
		p = (longint'(d) * gain + (1 << (GAIN_FRAC - 1))) >> GAIN_FRAC; // round half up
		return (p > PIX_MAX) ? DATA_WIDTH'(PIX_MAX) : DATA_WIDTH'(p);
	endfunction

	task automatic scramble_settings();
		nxt_mode = 2'(rand_bits(2));
		nxt_blk  = DATA_WIDTH'(rand_bits(DATA_WIDTH));
		nxt_gain = GAIN_WIDTH'(rand_bits(GAIN_WIDTH));
	endtask

	// sample outputs, then drive the next cycle
	task automatic drive_cycle(input logic fval, input logic lval, input logic [W-1:0] data);
		logic [W-1:0] exp_data;
		@(negedge clk);
		assert (o_fval == &fval_hist) else begin
			$display("Error %s: o_fval expected %b actual %b", cur_name, &fval_hist, o_fval);
			test_err++;
		end
		assert (o_lval == lval_hist[3]) else begin
			$display("Error %s: o_lval expected %b actual %b", cur_name, lval_hist[3], o_lval);
			test_err++;
		end
		if (o_lval) begin
			assert (exp_q.size() != 0) else begin
				$display("%s: a pixel came out when none was pending", cur_name);
				test_err++;
			end
			if (exp_q.size() != 0) begin
				exp_data = exp_q.pop_front();
				assert (o_data == exp_data) else begin
					$display("Error %s: pixels expected %h actual %h", cur_name, exp_data, o_data);
					test_err++;
				end
			end
		end else begin
			assert (o_data == '0) else begin
				$display("Error %s: blank data expected 0 actual %h", cur_name, o_data);
				test_err++;
			end
		end
		if (o_lval && !prev_lval)
			pulse_cnt++;
		prev_lval = o_lval;
		i_arst_n      = nxt_rst_n;
		i_fval        = fval;
		i_lval        = lval;
		i_data        = data;
		i_mode        = nxt_mode;
		i_black_level = nxt_blk;
		i_gain        = nxt_gain;
		fval_hist     = {fval_hist[5:0], fval};
		lval_hist     = {lval_hist[2:0], lval};
		if (!nxt_rst_n) begin // whole DUT cleared
			fval_hist = '0;
			lval_hist = '0;
			prev_lval = 1'b0;
			exp_q.delete();
		end
	endtask

	task automatic apply_reset(input int ncyc);
		nxt_rst_n = 1'b0;
		for (int i = 0; i < ncyc; i++)
			drive_cycle(1'b0, 1'b0, '0);
		nxt_rst_n = 1'b1;
	endtask

	// fval rise with the test settings, then 2 idle cycles
	task automatic frame_head(input int idx);
		nxt_mode = 2'(t_mode[idx]);
		nxt_blk  = DATA_WIDTH'(t_blk[idx]);
		nxt_gain = GAIN_WIDTH'(t_gain[idx]);
		drive_cycle(1'b1, 1'b0, '0);
		for (int i = 0; i < 2; i++) begin
			scramble_settings(); // must not reach the taps
			drive_cycle(1'b1, 1'b0, '0);
		end
	endtask

	task automatic drive_line(input int idx, input int npix, input int ngap);
		logic [W-1:0] word;
		logic [W-1:0] expw;
		for (int px = 0; px < npix; px++) begin
			for (int t = 0; t < CHANNEL_NUM; t++) begin
				word[t*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(rand_bits(DATA_WIDTH));
				expw[t*DATA_WIDTH +: DATA_WIDTH] = corr_pix(t_mode[idx], t_blk[idx],
					t_gain[idx], int'(word[t*DATA_WIDTH +: DATA_WIDTH]));
			end
			exp_q.push_back(expw);
			scramble_settings();
			drive_cycle(1'b1, 1'b1, word);
		end
		for (int g = 0; g < ngap; g++) begin
			scramble_settings();
			drive_cycle(1'b1, 1'b0, '0);
		end
	endtask

	// fval low until every pixel is out, at least 8 cycles
	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 || n < 8) begin
			drive_cycle(1'b0, 1'b0, '0);
			n++;
		end
	endtask

	task automatic start_test(input string name);
		cur_name  = name;
		test_err  = 0;
		pulse_cnt = 0;
	endtask

	task automatic report_test(input int lines);
		if (lines >= 0) begin
			assert (pulse_cnt == lines) else begin
				$display("Error %s: o_lval pulses expected %0d actual %0d",
					cur_name, lines, pulse_cnt);
				test_err++;
			end
		end
		if (test_err == 0) begin
			pass_cnt++;
			$display("ok    %s", cur_name);
		end else begin
			fail_cnt++;
			$display("FAIL  %s, %0d errors", cur_name, test_err);
		end
		err_cnt += test_err;
	endtask

	task automatic run_frame(input int idx);
		start_test(t_name[idx]);
		frame_head(idx);
		for (int ln = 0; ln < t_lines[idx]; ln++)
			drive_line(idx, t_pix[idx], 3);
		drain();
		report_test(t_lines[idx]);
	endtask

	// --------------------------------------------------
	// test table and run
	// --------------------------------------------------
	task automatic read_tests();
		int    fd, mode, blk, gain, lines, pix, total;
		string line, name;
		fd = $fopen("verif/pix_corr_tests.txt", "r");
		if (fd == 0)
			return;
		total = 60; // reset tests and a spare frame
		while ($fgets(line, fd)) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if ($sscanf(line, "%s %d %d %d %d %d", name, mode, blk, gain, lines, pix) == 6) begin
				t_name.push_back(name);
				t_mode.push_back(mode);
				t_blk.push_back(blk);
				t_gain.push_back(gain);
				t_lines.push_back(lines);
				t_pix.push_back(pix);
				total += 13 + lines * (pix + 3);
			end
		end
		$fclose(fd);
		cycle_limit = 2 * total;
	endtask

	task automatic run_all();
		apply_reset(3);
		drain();
		report_test(-1);
		for (int i = 0; i < t_name.size(); i++)
			run_frame(i);
		// reset in the middle of a line, then a clean frame
		start_test("reset_mid_frame");
		frame_head(0);
		drive_line(0, 6, 0);
		apply_reset(3);
		drain();
		report_test(-1);
		run_frame(0);
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	initial begin
		i_arst_n      = 1'b0;
		i_fval        = 1'b0;
		i_lval        = 1'b0;
		i_data        = '0;
		i_mode        = '0;
		i_black_level = '0;
		i_gain        = '0;
		nxt_rst_n     = 1'b0;
		nxt_mode      = '0;
		nxt_blk       = '0;
		nxt_gain      = '0;
		read_tests();
		if (t_name.size() == 0) begin
			$display("no tests could be read from verif/pix_corr_tests.txt");
			$display("Regression failed");
			$finish;
		end else begin
			run_all();
		end
	end

endmodule : pix_corr_tb

`default_nettype wire

/* verif/pix_corr_tests.txt */
# name  mode (0 bypass, 1 offset, 2 offset and gain)  black_level  gain (16 is 1.0)
# lines per frame  pixel clocks per line, all decimal
bypass_all        0    0    0  3  8
bypass_blk_set    0   64   99  2  6
offset_small      1   16    0  2 10
offset_clamp      1  200    0  2 10
gain_unity        2   20   16  2  8
gain_frac         2   10   11  3  8
gain_round_half   2    0   24  2  8
gain_saturate     2    5  200  2  8
gain_full_black   2  255   40  1  6
offset_short_ln   1   48   32  4  3
